// ==== design/color_conv.sv ====
`timescale 1ns/100ps
`include "ppu_defs.svh"

module color_conv (
  input  logic                    VCLK_Tx_o,
  input  logic                    nVRST_Tx_o,
  input  logic                    ypbpr_en_i,
  input  logic [`PPU_SYNC_W-1:0]  sync_i,
  input  logic [`PPU_COLOR_W-1:0] red_i,
  input  logic [`PPU_COLOR_W-1:0] green_i,
  input  logic [`PPU_COLOR_W-1:0] blue_i,
  output logic [`PPU_SYNC_W-1:0]  sync_o,
  output logic [`PPU_COLOR_W-1:0] ch0_o,
  output logic [`PPU_COLOR_W-1:0] ch1_o,
  output logic [`PPU_COLOR_W-1:0] ch2_o
);

  // Coefficients scaled by 256
  localparam logic signed [17:0] C_Y_R  = 18'sd77;
  localparam logic signed [17:0] C_Y_G  = 18'sd150;
  localparam logic signed [17:0] C_Y_B  = 18'sd29;
  localparam logic signed [17:0] C_PB_R = -18'sd43;
  localparam logic signed [17:0] C_PB_G = -18'sd85;
  localparam logic signed [17:0] C_PB_B = 18'sd128;
  localparam logic signed [17:0] C_PR_R = 18'sd128;
  localparam logic signed [17:0] C_PR_G = -18'sd107;
  localparam logic signed [17:0] C_PR_B = -18'sd21;

  logic signed [17:0]      r_s, g_s, b_s;
  logic signed [17:0]      y_r, y_g, y_b;
  logic signed [17:0]      pb_r, pb_g, pb_b;
  logic signed [17:0]      pr_r, pr_g, pr_b;
  logic [`PPU_SYNC_W-1:0]  sync_s1;
  logic [`PPU_COLOR_W-1:0] red_s1, green_s1, blue_s1;
  logic signed [19:0]      y_val, pb_val, pr_val;

  // Saturate to 0..255
  function automatic logic [`PPU_COLOR_W-1:0] clamp8(input logic signed [19:0] v);
    if (v < 0) begin
      return '0;
    end else if (v > 20'sd255) begin
      return '1;
    end
    return v[`PPU_COLOR_W-1:0];
  endfunction

  // Channels as positive signed operands
  assign r_s = $signed({10'd0, red_i});
  assign g_s = $signed({10'd0, green_i});
  assign b_s = $signed({10'd0, blue_i});

  // ================================================
  // Stage 1: products
  // ================================================
  always_ff @(posedge VCLK_Tx_o) begin
    y_r  <= C_Y_R * r_s;
    y_g  <= C_Y_G * g_s;
    y_b  <= C_Y_B * b_s;
    pb_r <= C_PB_R * r_s;
    pb_g <= C_PB_G * g_s;
    pb_b <= C_PB_B * b_s;
    pr_r <= C_PR_R * r_s;
    pr_g <= C_PR_G * g_s;
    pr_b <= C_PR_B * b_s;
    // Bypass copy keeps the same latency
    red_s1   <= red_i;
    green_s1 <= green_i;
    blue_s1  <= blue_i;
  end

  // ================================================
  // Stage 2: sums, scaling, offset and clamp
  // ================================================
  assign y_val  = (20'(y_r) + 20'(y_g) + 20'(y_b)) >>> 8;
  assign pb_val = ((20'(pb_r) + 20'(pb_g) + 20'(pb_b)) >>> 8) + 20'sd128;
  assign pr_val = ((20'(pr_r) + 20'(pr_g) + 20'(pr_b)) >>> 8) + 20'sd128;

  always_ff @(posedge VCLK_Tx_o) begin
    if (ypbpr_en_i) begin
      ch0_o <= clamp8(pr_val);
      ch1_o <= clamp8(y_val);
      ch2_o <= clamp8(pb_val);
    end else begin
      ch0_o <= red_s1;
      ch1_o <= green_s1;
      ch2_o <= blue_s1;
    end
  end

  // Sync follows the two colour stages
  always_ff @(posedge VCLK_Tx_o) begin
    if (!nVRST_Tx_o) begin
      sync_s1 <= '0;
      sync_o  <= '0;
    end else begin
      sync_s1 <= sync_i;
      sync_o  <= sync_s1;
    end
  end

endmodule

// ==== design/out_stage.sv ====
`timescale 1ns/100ps
`include "ppu_defs.svh"

module out_stage (
  input  logic                      VCLK_Tx_o,
  input  logic                      nVRST_Tx_o,
  input  logic                      blank_i,
  input  logic [1:0]                align_dly_i,
  input  logic                      rgsb_en_i,
  input  logic                      ypbpr_en_i,
  input  logic                      vga_sync_i,
  input  ppu_pkg::filter_e          filter_i,
  input  logic [`PPU_SYNC_W-1:0]    sync_i,
  input  logic [`PPU_COLOR_W-1:0]   ch0_i,
  input  logic [`PPU_COLOR_W-1:0]   ch1_i,
  input  logic [`PPU_COLOR_W-1:0]   ch2_i,
  output logic [3*`PPU_COLOR_W-1:0] vd_o,
  output logic [`PPU_SYNC_W-1:0]    sync_o,
  output logic [1:0]                ncsync_o,
  output logic                      nvsync_or_f2_o,
  output logic                      nhsync_or_f1_o
);

  logic [3*`PPU_COLOR_W-1:0] col_in;
  logic [3*`PPU_COLOR_W-1:0] col_sr [2];
  logic [3*`PPU_COLOR_W-1:0] col_tap;
  ppu_pkg::filter_e          filter_q;
  logic                      csync_adv;

  // ================================================
  // Colour alignment
  // ================================================

  assign col_in = {ch0_i, ch1_i, ch2_i};

  // Two-deep delay line, no reset on payload
  always_ff @(posedge VCLK_Tx_o) begin
    col_sr[0] <= col_in;
    col_sr[1] <= col_sr[0];
  end

  // Delay 3 behaves as 2
  always_comb begin
    case (align_dly_i)
      2'd0:    col_tap = col_in;
      2'd1:    col_tap = col_sr[0];
      default: col_tap = col_sr[1];
    endcase
  end

  // Output registers, blanked during hold-off
  always_ff @(posedge VCLK_Tx_o) begin
    if (!nVRST_Tx_o) begin
      vd_o     <= '0;
      sync_o   <= '0;
      filter_q <= ppu_pkg::FLT_SD;
    end else begin
      filter_q <= filter_i;
      if (blank_i) begin
        vd_o   <= '0;
        sync_o <= '0;
      end else begin
        vd_o   <= col_tap;
        sync_o <= sync_i;
      end
    end
  end

  // ================================================
  // Sync and filter pins
  // ================================================

  // Second csync pin only for the video encoder modes
  assign csync_adv = (rgsb_en_i | ypbpr_en_i) ? sync_o[`PPU_SYNC_NCSYNC] : 1'b0;
  assign ncsync_o  = {sync_o[`PPU_SYNC_NCSYNC], csync_adv};

  // Shared pins, VGA sync jumper or filter board selects
  // F1 set only for HD, F2 set only for ED
  assign nvsync_or_f2_o = vga_sync_i ? sync_o[`PPU_SYNC_NVSYNC]
                                     : (filter_q[0] & ~filter_q[1]);
  assign nhsync_or_f1_o = vga_sync_i ? sync_o[`PPU_SYNC_NHSYNC]
                                     : (filter_q[1] & ~filter_q[0]);

endmodule

// ==== design/ppu_cfg_regs.sv ====
`timescale 1ns/100ps
`include "ppu_defs.svh"

module ppu_cfg_regs (
  input  logic                  VCLK_Tx_o,
  input  logic                  nVRST_Tx_o,
  input  logic [`PPU_CFG_W-1:0] config_i,
  output logic                  testpat_en_o,
  output logic                  ypbpr_en_o,
  output logic                  rgsb_en_o,
  output logic                  vga_sync_o,
  output logic [1:0]            align_dly_o,
  output ppu_pkg::filter_e      filter_o,
  output logic                  blank_o
);

  localparam int HOLD_W = $clog2(`PPU_HOLD_CYCLES);

  logic [`PPU_CFG_W-1:0] cfg_q;
  logic                  testpat_prev;
  logic                  testpat_chg;
  ppu_pkg::hold_state_e  hold_state;
  logic [HOLD_W-1:0]     hold_cnt;
  ppu_pkg::linemult_e    lm_mode;
  logic [1:0]            flt_field;

  // ================================================
  // Config word register
  // ================================================

  // Sampled every clock, controls valid one cycle later
  always_ff @(posedge VCLK_Tx_o) begin
    if (!nVRST_Tx_o) begin
      cfg_q <= '0;
    end else begin
      cfg_q <= config_i;
    end
  end

  // Plain control bits
  assign testpat_en_o = cfg_q[`PPU_CFG_TESTPAT];
  assign ypbpr_en_o   = cfg_q[`PPU_CFG_YPBPR];
  assign rgsb_en_o    = cfg_q[`PPU_CFG_RGSB];
  assign vga_sync_o   = cfg_q[`PPU_CFG_VGASYNC];
  assign align_dly_o  = cfg_q[`PPU_CFG_ALIGN];

  // Filter select
  // Field 0 is auto and follows the line multiplier
  // Manual values 1..3 map to codes 0..2
  assign flt_field = cfg_q[`PPU_CFG_FILTER];
  assign lm_mode   = ppu_pkg::linemult_e'(cfg_q[`PPU_CFG_LINEMULT]);

  always_comb begin
    if (flt_field == 2'd0) begin
      filter_o = ppu_pkg::filter_e'(lm_mode);
    end else begin
      filter_o = ppu_pkg::filter_e'(flt_field - 2'd1);
    end
  end

  // ================================================
  // Hold-off sequencer
  // ================================================

  // Toggle of the registered test pattern bit
  assign testpat_chg = cfg_q[`PPU_CFG_TESTPAT] ^ testpat_prev;

  always_ff @(posedge VCLK_Tx_o) begin
    if (!nVRST_Tx_o) begin
      testpat_prev <= 1'b0;
      hold_state   <= ppu_pkg::HOLD_IDLE;
      hold_cnt     <= '0;
    end else begin
      testpat_prev <= cfg_q[`PPU_CFG_TESTPAT];
      case (hold_state)
        ppu_pkg::HOLD_IDLE: begin
          if (testpat_chg) begin
            hold_state <= ppu_pkg::HOLD_ACTIVE;
            hold_cnt   <= HOLD_W'(`PPU_HOLD_CYCLES - 1);
          end
        end
        ppu_pkg::HOLD_ACTIVE: begin
          // Another toggle restarts the full period
          if (testpat_chg) begin
            hold_cnt <= HOLD_W'(`PPU_HOLD_CYCLES - 1);
          end else if (hold_cnt == '0) begin
            hold_state <= ppu_pkg::HOLD_IDLE;
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end
        default: begin
          hold_state <= ppu_pkg::HOLD_IDLE;
        end
      endcase
    end
  end

  assign blank_o = (hold_state == ppu_pkg::HOLD_ACTIVE);

endmodule

// ==== design/ppu_out_top.sv ====
`timescale 1ns/100ps
`include "ppu_defs.svh"

module ppu_out_top (
  input  logic                      VCLK_Tx_o,
  input  logic                      nVRST_Tx_o,
  input  logic [`PPU_SYNC_W-1:0]    sync_i,
  input  logic [`PPU_COLOR_W-1:0]   red_i,
  input  logic [`PPU_COLOR_W-1:0]   green_i,
  input  logic [`PPU_COLOR_W-1:0]   blue_i,
  input  logic [`PPU_CFG_W-1:0]     config_i,
  output logic [3*`PPU_COLOR_W-1:0] vd_o,
  output logic [`PPU_SYNC_W-1:0]    sync_o,
  output logic [1:0]                ncsync_o,
  output logic                      nvsync_or_f2_o,
  output logic                      nhsync_or_f1_o
);

  // Decoded controls
  logic             testpat_en;
  logic             ypbpr_en;
  logic             rgsb_en;
  logic             vga_sync;
  logic [1:0]       align_dly;
  ppu_pkg::filter_e filter;
  logic             blank;

  // Pattern generator to converter
  logic [`PPU_SYNC_W-1:0]  tp_sync;
  logic [`PPU_COLOR_W-1:0] tp_red, tp_green, tp_blue;

  // Converter to output stage
  logic [`PPU_SYNC_W-1:0]  cc_sync;
  logic [`PPU_COLOR_W-1:0] cc_ch0, cc_ch1, cc_ch2;

  // ================================================
  // Control block
  // ================================================
  ppu_cfg_regs cfg_regs_u (
    .VCLK_Tx_o    (VCLK_Tx_o),
    .nVRST_Tx_o   (nVRST_Tx_o),
    .config_i     (config_i),
    .testpat_en_o (testpat_en),
    .ypbpr_en_o   (ypbpr_en),
    .rgsb_en_o    (rgsb_en),
    .vga_sync_o   (vga_sync),
    .align_dly_o  (align_dly),
    .filter_o     (filter),
    .blank_o      (blank)
  );

  // ================================================
  // Pixel pipeline
  // ================================================
  testpattern_gen testpattern_u (
    .VCLK_Tx_o    (VCLK_Tx_o),
    .nVRST_Tx_o   (nVRST_Tx_o),
    .testpat_en_i (testpat_en),
    .sync_i       (sync_i),
    .red_i        (red_i),
    .green_i      (green_i),
    .blue_i       (blue_i),
    .sync_o       (tp_sync),
    .red_o        (tp_red),
    .green_o      (tp_green),
    .blue_o       (tp_blue)
  );

  color_conv color_conv_u (
    .VCLK_Tx_o  (VCLK_Tx_o),
    .nVRST_Tx_o (nVRST_Tx_o),
    .ypbpr_en_i (ypbpr_en),
    .sync_i     (tp_sync),
    .red_i      (tp_red),
    .green_i    (tp_green),
    .blue_i     (tp_blue),
    .sync_o     (cc_sync),
    .ch0_o      (cc_ch0),
    .ch1_o      (cc_ch1),
    .ch2_o      (cc_ch2)
  );

  out_stage out_stage_u (
    .VCLK_Tx_o      (VCLK_Tx_o),
    .nVRST_Tx_o     (nVRST_Tx_o),
    .blank_i        (blank),
    .align_dly_i    (align_dly),
    .rgsb_en_i      (rgsb_en),
    .ypbpr_en_i     (ypbpr_en),
    .vga_sync_i     (vga_sync),
    .filter_i       (filter),
    .sync_i         (cc_sync),
    .ch0_i          (cc_ch0),
    .ch1_i          (cc_ch1),
    .ch2_i          (cc_ch2),
    .vd_o           (vd_o),
    .sync_o         (sync_o),
    .ncsync_o       (ncsync_o),
    .nvsync_or_f2_o (nvsync_or_f2_o),
    .nhsync_or_f1_o (nhsync_or_f1_o)
  );

endmodule

// ==== design/ppu_pkg.sv ====
package ppu_pkg;

  // ================================================
  // Hold-off sequencer
  // ================================================

  // Idle passes video, active blanks the output stage
  typedef enum logic {
    HOLD_IDLE   = 1'b0,
    HOLD_ACTIVE = 1'b1
  } hold_state_e;

  // ================================================
  // Video filter add-on codes
  // ================================================

  // Encoded as {F1, F2} on the filter board
  // SD   9.5 MHz
  // ED  18.0 MHz
  // HD  36.0 MHz
  // FHD 72.0 MHz
  typedef enum logic [1:0] {
    FLT_SD  = 2'd0,
    FLT_ED  = 2'd1,
    FLT_HD  = 2'd2,
    FLT_FHD = 2'd3
  } filter_e;

  // Line multiplier mode
  // Values line up with the filter code picked in auto mode
  typedef enum logic [1:0] {
    LM_X1 = 2'd0,
    LM_X2 = 2'd1,
    LM_X3 = 2'd2
  } linemult_e;

endpackage

// ==== design/testpattern_gen.sv ====
`timescale 1ns/100ps
`include "ppu_defs.svh"

module testpattern_gen (
  input  logic                    VCLK_Tx_o,
  input  logic                    nVRST_Tx_o,
  input  logic                    testpat_en_i,
  input  logic [`PPU_SYNC_W-1:0]  sync_i,
  input  logic [`PPU_COLOR_W-1:0] red_i,
  input  logic [`PPU_COLOR_W-1:0] green_i,
  input  logic [`PPU_COLOR_W-1:0] blue_i,
  output logic [`PPU_SYNC_W-1:0]  sync_o,
  output logic [`PPU_COLOR_W-1:0] red_o,
  output logic [`PPU_COLOR_W-1:0] green_o,
  output logic [`PPU_COLOR_W-1:0] blue_o
);

  logic                   hs_rise;
  logic                   vs_rise;
  logic [`PPU_HCNT_W-1:0] h_cnt;
  logic [`PPU_HCNT_W-1:0] h_nxt;
  logic [`PPU_VCNT_W-1:0] v_cnt;
  logic [`PPU_VCNT_W-1:0] v_nxt;
  logic                   grid_on;

  // ================================================
  // Sync edges and position counters
  // ================================================

  // Registered sync output doubles as the previous sample
  assign hs_rise = sync_i[`PPU_SYNC_NHSYNC] & ~sync_o[`PPU_SYNC_NHSYNC];
  assign vs_rise = sync_i[`PPU_SYNC_NVSYNC] & ~sync_o[`PPU_SYNC_NVSYNC];

  // Position of the current pixel
  // The pixel at an nHSYNC rise is column 0
  always_comb begin
    h_nxt = hs_rise ? '0 : h_cnt + 1'b1;
    if (vs_rise) begin
      v_nxt = '0;
    end else if (hs_rise) begin
      v_nxt = v_cnt + 1'b1;
    end else begin
      v_nxt = v_cnt;
    end
  end

  always_ff @(posedge VCLK_Tx_o) begin
    if (!nVRST_Tx_o) begin
      h_cnt  <= '0;
      v_cnt  <= '0;
      sync_o <= '0;
    end else begin
      h_cnt  <= h_nxt;
      v_cnt  <= v_nxt;
      // Sync passes unchanged in both modes
      sync_o <= sync_i;
    end
  end

  // ================================================
  // Grid pattern or live video
  // ================================================

  // Checkerboard of 8x8 pixel cells
  assign grid_on = h_nxt[`PPU_GRID_BIT] ^ v_nxt[`PPU_GRID_BIT];

  always_ff @(posedge VCLK_Tx_o) begin
    if (testpat_en_i) begin
      red_o   <= {`PPU_COLOR_W{grid_on}};
      green_o <= {`PPU_COLOR_W{grid_on}};
      blue_o  <= {`PPU_COLOR_W{grid_on}};
    end else begin
      red_o   <= red_i;
      green_o <= green_i;
      blue_o  <= blue_i;
    end
  end

endmodule

// ==== include/ppu_defs.svh ====
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// ================================================
// Data path widths
// ================================================
`define PPU_COLOR_W      8
`define PPU_SYNC_W       4
`define PPU_CFG_W        16

// Sync group order, MSB first: nVSYNC, nCLAMP, nHSYNC, nCSYNC
`define PPU_SYNC_NVSYNC  3
`define PPU_SYNC_NHSYNC  1
`define PPU_SYNC_NCSYNC  0

// ================================================
// Configuration word fields
// ================================================
`define PPU_CFG_TESTPAT  0
`define PPU_CFG_YPBPR    1
`define PPU_CFG_RGSB     2
`define PPU_CFG_VGASYNC  3
`define PPU_CFG_FILTER   5:4
`define PPU_CFG_LINEMULT 7:6
`define PPU_CFG_ALIGN    9:8
// Bits 15:10 reserved

// Output blanking after a test pattern toggle
`define PPU_HOLD_CYCLES  16

// Test pattern counters and grid cell size (2**3 pixels)
`define PPU_HCNT_W       10
`define PPU_VCNT_W       10
`define PPU_GRID_BIT     3

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the output stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing -Wno-fatal -f vlog.f --top-module ppu_out_tb -o sim_ppu_out
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_ppu_out > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi

if ! grep -q "test passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0

// ==== tb/ppu_out_checker.sv ====
`timescale 1ns/100ps
`include "ppu_defs.svh"

module ppu_out_checker (
  input  logic                      VCLK_Tx_o,
  input  logic                      nVRST_Tx_o,
  input  logic [`PPU_SYNC_W-1:0]    sync_i,
  input  logic [`PPU_COLOR_W-1:0]   red_i,
  input  logic [`PPU_COLOR_W-1:0]   green_i,
  input  logic [`PPU_COLOR_W-1:0]   blue_i,
  input  logic [`PPU_CFG_W-1:0]     config_i,
  input  logic [3*`PPU_COLOR_W-1:0] vd_i,
  input  logic [`PPU_SYNC_W-1:0]    out_sync_i,
  input  logic [1:0]                ncsync_i,
  input  logic                      nvsync_or_f2_i,
  input  logic                      nhsync_or_f1_i,
  input  int                        test_id_i,
  output int                        checks_o,
  output int                        errors_o
);

  // Expected colour and sync per input sample, index 0 is the newest
  logic [23:0] col_hist [0:7];
  logic [3:0]  sync_hist [0:7];
  logic [15:0] prev_cfg;
  logic [3:0]  prev_sync;
  logic [9:0]  h_cnt;
  logic [9:0]  v_cnt;
  logic        hs_rise;
  logic        vs_rise;
  logic        grid;
  logic [23:0] exp_col;
  logic [3:0]  exp_sync;
  logic [1:0]  code;
  logic        exp_f1;
  logic        exp_f2;
  int          sample = 0;
  int          skip_until = 0;
  int          blank_from = -1;
  int          blank_to = -2;
  int          cur_test = 0;
  int          test_checks = 0;
  int          test_errors = 0;
  int          checks = 0;
  int          errors = 0;
  int          align;
  int          i;

  assign checks_o = checks;
  assign errors_o = errors;

  // ==================================================
  // Reference model
  // ==================================================

  function automatic logic [7:0] sat8(input int v);
    if (v < 0) return 8'd0;
    if (v > 255) return 8'd255;
    return v[7:0];
  endfunction

  // Expected {ch0, ch1, ch2} for one input pixel
  function automatic logic [23:0] ref_pixel(input int r, input int g, input int b,
                                            input logic grid_on, input logic tp,
                                            input logic yp);
    int y;
    int pb;
    int pr;
    if (tp) begin
      r = grid_on ? 255 : 0;
      g = r;
      b = r;
    end
    if (!yp) return {r[7:0], g[7:0], b[7:0]};
    y  = (77 * r + 150 * g + 29 * b) >>> 8;
    pb = 128 + ((-43 * r - 85 * g + 128 * b) >>> 8);
    pr = 128 + ((128 * r - 107 * g - 21 * b) >>> 8);
    return {sat8(pr), sat8(y), sat8(pb)};
  endfunction

  // Auto takes the line multiplier code, manual v gives v-1
  function automatic logic [1:0] filter_code(input logic [15:0] cfg);
    logic [1:0] fld;
    fld = cfg[`PPU_CFG_FILTER];
    if (fld == 2'd0) return cfg[`PPU_CFG_LINEMULT];
    return fld - 2'd1;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "bypass";
      2:       return "ypbpr";
      3:       return "alignment";
      4:       return "testpattern_holdoff";
      5:       return "sync_filter_pins";
      default: return "unknown";
    endcase
  endfunction

  // ==================================================
  // Comparison helpers
  // ==================================================

  task automatic compare(input string what, input logic [23:0] exp, input logic [23:0] act);
    checks++;
    test_checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("FAIL %s %s: expected %h, actual %h", test_name(cur_test), what, exp, act);
    end
  endtask

  task automatic check_outputs();
    align = int'(config_i[`PPU_CFG_ALIGN]);
    // Delay 3 acts as 2
    if (align == 3) align = 2;
    exp_col  = col_hist[4 + align];
    exp_sync = sync_hist[4];
    compare("vd_o", exp_col, vd_i);
    compare("sync_o", {20'd0, exp_sync}, {20'd0, out_sync_i});
    compare("ncsync_o[1]", {23'd0, exp_sync[`PPU_SYNC_NCSYNC]}, {23'd0, ncsync_i[1]});
    compare("ncsync_o[0]",
            {23'd0, exp_sync[`PPU_SYNC_NCSYNC] &
                    (config_i[`PPU_CFG_RGSB] | config_i[`PPU_CFG_YPBPR])},
            {23'd0, ncsync_i[0]});
    if (config_i[`PPU_CFG_VGASYNC]) begin
      exp_f2 = exp_sync[`PPU_SYNC_NVSYNC];
      exp_f1 = exp_sync[`PPU_SYNC_NHSYNC];
    end else begin
      code   = filter_code(config_i);
      exp_f1 = code[1] & ~code[0];
      exp_f2 = code[0] & ~code[1];
    end
    compare("nvsync_or_f2_o", {23'd0, exp_f2}, {23'd0, nvsync_or_f2_i});
    compare("nhsync_or_f1_o", {23'd0, exp_f1}, {23'd0, nhsync_or_f1_i});
  endtask

  // Hold-off window, colour and sync forced low
  task automatic check_blank();
    compare("vd_o blank", 24'd0, vd_i);
    compare("sync_o blank", 24'd0, {20'd0, out_sync_i});
    compare("ncsync_o blank", 24'd0, {22'd0, ncsync_i});
  endtask

  task automatic report_test();
    if (test_checks == 0) begin
      errors++;
      $display("%s: no outputs were compared", test_name(cur_test));
    end else begin
      $display("%s finished: %0d checks, %0d errors",
               test_name(cur_test), test_checks, test_errors);
    end
  endtask

  // ==================================================
  // Sampling and comparison
  // ==================================================

  // Inputs and outputs are both stable at the rising edge
  always @(posedge VCLK_Tx_o) begin
    if (test_id_i != cur_test) begin
      if (cur_test != 0) report_test();
      cur_test    = test_id_i;
      test_checks = 0;
      test_errors = 0;
    end
    sample = sample + 1;
    if (!nVRST_Tx_o) begin
      h_cnt      = '0;
      v_cnt      = '0;
      prev_sync  = '0;
      prev_cfg   = '0;
      skip_until = sample + 8;
    end else begin
      // Config change, wait out the longest pipeline path
      if (config_i != prev_cfg) begin
        if (sample + 8 > skip_until) skip_until = sample + 8;
        // Pattern toggle, registered then sequenced, blanks 16 outputs
        if (config_i[`PPU_CFG_TESTPAT] != prev_cfg[`PPU_CFG_TESTPAT]) begin
          blank_from = sample + 3;
          blank_to   = sample + 2 + `PPU_HOLD_CYCLES;
          skip_until = blank_to;
        end
      end
      prev_cfg = config_i;
      // Grid position from the driven sync
      hs_rise = sync_i[`PPU_SYNC_NHSYNC] & ~prev_sync[`PPU_SYNC_NHSYNC];
      vs_rise = sync_i[`PPU_SYNC_NVSYNC] & ~prev_sync[`PPU_SYNC_NVSYNC];
      h_cnt   = hs_rise ? 10'd0 : h_cnt + 10'd1;
      if (vs_rise) v_cnt = 10'd0;
      else if (hs_rise) v_cnt = v_cnt + 10'd1;
      prev_sync = sync_i;
      grid = h_cnt[3] ^ v_cnt[3];
      for (i = 7; i > 0; i--) begin
        col_hist[i]  = col_hist[i-1];
        sync_hist[i] = sync_hist[i-1];
      end
      col_hist[0]  = ref_pixel(int'(red_i), int'(green_i), int'(blue_i), grid,
                               config_i[`PPU_CFG_TESTPAT], config_i[`PPU_CFG_YPBPR]);
      sync_hist[0] = sync_i;
      if (cur_test != 0) begin
        if (sample >= blank_from && sample <= blank_to) check_blank();
        else if (sample > skip_until) check_outputs();
      end
    end
  end

endmodule

// ==== tb/ppu_out_tb.sv ====
`timescale 1ns/100ps
`include "ppu_defs.svh"

module ppu_out_tb;

  // Test lengths in cycles
  // Run limit is 1.5 times their sum
  localparam int TOTAL_CYCLES = 300 + 300 + 500 + 2300 + 800;
  localparam int CYCLE_LIMIT  = TOTAL_CYCLES * 3 / 2;
  localparam int NUM_TESTS    = 5;

  logic        VCLK_Tx_o;
  logic        nVRST_Tx_o;
  logic [3:0]  sync_i;
  logic [7:0]  red_i;
  logic [7:0]  green_i;
  logic [7:0]  blue_i;
  logic [15:0] config_i;
  logic [23:0] vd_o;
  logic [3:0]  sync_o;
  logic [1:0]  ncsync_o;
  logic        nvsync_or_f2_o;
  logic        nhsync_or_f1_o;
  int          test_id = 0;
  int          checks;
  int          errors;
  int          cycles = 0;
  int          px = 0;
  int          line = 0;
  integer      seed = 32'h3771_bffb;
  logic [31:0] rnd;

  ppu_out_top uut (
    .VCLK_Tx_o      (VCLK_Tx_o),
    .nVRST_Tx_o     (nVRST_Tx_o),
    .sync_i         (sync_i),
    .red_i          (red_i),
    .green_i        (green_i),
    .blue_i         (blue_i),
    .config_i       (config_i),
    .vd_o           (vd_o),
    .sync_o         (sync_o),
    .ncsync_o       (ncsync_o),
    .nvsync_or_f2_o (nvsync_or_f2_o),
    .nhsync_or_f1_o (nhsync_or_f1_o)
  );

  ppu_out_checker checker_u (
    .VCLK_Tx_o      (VCLK_Tx_o),
    .nVRST_Tx_o     (nVRST_Tx_o),
    .sync_i         (sync_i),
    .red_i          (red_i),
    .green_i        (green_i),
    .blue_i         (blue_i),
    .config_i       (config_i),
    .vd_i           (vd_o),
    .out_sync_i     (sync_o),
    .ncsync_i       (ncsync_o),
    .nvsync_or_f2_i (nvsync_or_f2_o),
    .nhsync_or_f1_i (nhsync_or_f1_o),
    .test_id_i      (test_id),
    .checks_o       (checks),
    .errors_o       (errors)
  );

  // ==================================================
  // Clock and stimulus
  // ==================================================

  initial begin
    VCLK_Tx_o = 1'b0;
    forever #50 VCLK_Tx_o = ~VCLK_Tx_o;
  end

  // 64-pixel lines with 8-pixel nHSYNC pulses
  // 2-line nVSYNC pulse every 32 lines
  always @(negedge VCLK_Tx_o) begin
    rnd     = $random(seed);
    red_i   = rnd[7:0];
    green_i = rnd[15:8];
    blue_i  = rnd[23:16];
    sync_i[`PPU_SYNC_NHSYNC] = (px >= 8);
    sync_i[`PPU_SYNC_NVSYNC] = (line >= 2);
    // Clamp pulse right after hsync
    sync_i[2] = !(px >= 8 && px < 16);
    sync_i[`PPU_SYNC_NCSYNC] = (px >= 8) && (line >= 2);
    px = px + 1;
    if (px == 64) begin
      px   = 0;
      line = (line + 1) % 32;
    end
  end

  function automatic logic [15:0] cfg_word(input logic tp, input logic yp, input logic rg,
                                           input logic vga, input logic [1:0] flt,
                                           input logic [1:0] lm, input logic [1:0] al);
    logic [15:0] w;
    w = '0;
    w[`PPU_CFG_TESTPAT]  = tp;
    w[`PPU_CFG_YPBPR]    = yp;
    w[`PPU_CFG_RGSB]     = rg;
    w[`PPU_CFG_VGASYNC]  = vga;
    w[`PPU_CFG_FILTER]   = flt;
    w[`PPU_CFG_LINEMULT] = lm;
    w[`PPU_CFG_ALIGN]    = al;
    return w;
  endfunction

  // Apply one config word for a number of cycles
  task automatic hold_cfg(input logic [15:0] cfg, input int n);
    @(negedge VCLK_Tx_o);
    config_i = cfg;
    repeat (n - 1) @(negedge VCLK_Tx_o);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    nVRST_Tx_o = 1'b0;
    config_i   = '0;
    sync_i     = '0;
    red_i      = '0;
    green_i    = '0;
    blue_i     = '0;
    // Reset spans two rising edges
    repeat (2) @(posedge VCLK_Tx_o);
    @(negedge VCLK_Tx_o);
    nVRST_Tx_o = 1'b1;
    test_id = 1;
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd0, 2'd0, 2'd0), 300);
    test_id = 2;
    hold_cfg(cfg_word(0, 1, 0, 0, 2'd0, 2'd0, 2'd0), 300);
    test_id = 3;
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd0, 2'd0, 2'd1), 150);
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd0, 2'd0, 2'd2), 150);
    hold_cfg(cfg_word(0, 1, 0, 0, 2'd0, 2'd0, 2'd3), 100);
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd0, 2'd0, 2'd0), 100);
    // Full frame with the pattern and then back to live video
    test_id = 4;
    hold_cfg(cfg_word(1, 0, 0, 0, 2'd0, 2'd0, 2'd0), 2200);
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd0, 2'd0, 2'd0), 100);
    test_id = 5;
    hold_cfg(cfg_word(0, 0, 1, 1, 2'd0, 2'd0, 2'd0), 100);
    hold_cfg(cfg_word(0, 0, 1, 0, 2'd0, 2'd0, 2'd0), 100);
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd0, 2'd1, 2'd0), 100);
    hold_cfg(cfg_word(0, 0, 1, 0, 2'd0, 2'd2, 2'd0), 100);
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd1, 2'd2, 2'd0), 100);
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd2, 2'd0, 2'd0), 100);
    hold_cfg(cfg_word(0, 0, 0, 0, 2'd3, 2'd1, 2'd0), 100);
    hold_cfg(cfg_word(0, 1, 0, 0, 2'd0, 2'd1, 2'd0), 100);
    // Let the checker close the last test
    test_id = 0;
    repeat (3) @(negedge VCLK_Tx_o);
    $display("tests: %0d  checks: %0d  errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Run limit
  always @(posedge VCLK_Tx_o) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("test failed");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+include
design/ppu_pkg.sv
design/ppu_cfg_regs.sv
design/testpattern_gen.sv
design/color_conv.sv
design/out_stage.sv
design/ppu_out_top.sv
tb/ppu_out_checker.sv
tb/ppu_out_tb.sv
